// File: jbus_addr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module jbus_addr_decoder (
	input  wire                                 clk,
	input  wire                                 reset,

	// from the bridge
	input  wire                                 up_en_i,
	input  wire                                 up_we_i,
	input  wire  [wbjb_pkg::SEL_WIDTH-1:0]      up_sel_i,
	input  wire  [wbjb_pkg::ADDR_WIDTH-1:0]     up_addr_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     up_wdata_i,
	output logic [wbjb_pkg::DATA_WIDTH-1:0]     up_rdata_o,
	output logic                                up_ready_o,

	// memory
	output logic                                ram_en_o,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     ram_rdata_i,
	input  wire                                 ram_ready_i,

	// registers
	output logic                                reg_en_o,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     reg_rdata_i,
	input  wire                                 reg_ready_i,

	// fanned out to both slaves
	output logic                                dn_we_o,
	output logic [wbjb_pkg::SEL_WIDTH-1:0]      dn_sel_o,
	output logic [wbjb_pkg::ADDR_WIDTH-1:0]     dn_addr_o,
	output logic [wbjb_pkg::DATA_WIDTH-1:0]     dn_wdata_o
);
	import wbjb_pkg::*;

	logic sel_ram;
	logic addr_ready;
	logic owner_ready;
	logic owed_q;
	logic owed_ram_q;

	assign sel_ram = (up_addr_i[ADDR_WIDTH-1] == SEL_RAM);

	// ------------------------------------------------------------
	// ready and read data steering
	// ------------------------------------------------------------

	assign addr_ready  = sel_ram ? ram_ready_i : reg_ready_i;
	assign owner_ready = owed_ram_q ? ram_ready_i : reg_ready_i;

	// an owed read has to drain before the next access can go
	assign up_ready_o = addr_ready & (~owed_q | owner_ready);
	assign up_rdata_o = owed_ram_q ? ram_rdata_i : reg_rdata_i;

	// ------------------------------------------------------------
	// owed-read tracking
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			owed_q     <= 1'b0;
			owed_ram_q <= 1'b0;
		end else if (up_ready_o) begin
			owed_q <= up_en_i & ~up_we_i;
			if (up_en_i && !up_we_i) begin
				owed_ram_q <= sel_ram;
			end
		end
	end

	// keep the request off a slave while another one still owes data
	assign ram_en_o = up_en_i & sel_ram & (~owed_q | owner_ready);
	assign reg_en_o = up_en_i & ~sel_ram & (~owed_q | owner_ready);

	assign dn_we_o    = up_we_i;
	assign dn_sel_o   = up_sel_i;
	assign dn_addr_o  = up_addr_i;
	assign dn_wdata_o = up_wdata_i;

	a_one_slave: assert property (@(posedge clk) disable iff (reset)
		!(ram_en_o && reg_en_o));

endmodule

`default_nettype wire

// File: jbus_gpio_regs.sv
`timescale 1ns/10ps
`default_nettype none

module jbus_gpio_regs (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 en_i,
	input  wire                                 we_i,
	input  wire  [wbjb_pkg::SEL_WIDTH-1:0]      sel_i,
	input  wire  [wbjb_pkg::ADDR_WIDTH-1:0]     addr_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     wdata_i,
	output logic [wbjb_pkg::DATA_WIDTH-1:0]     rdata_o,
	output logic                                ready_o,
	output logic [wbjb_pkg::GPIO_WIDTH-1:0]     gpio_o
);
	import wbjb_pkg::*;

	logic [DATA_WIDTH-1:0]     regs [REG_COUNT];
	logic [DATA_WIDTH-1:0]     rdata_q;
	logic [REG_ADDR_WIDTH-1:0] idx;

	assign idx = addr_i[REG_ADDR_WIDTH-1:0];

	// never stalls
	assign ready_o = 1'b1;

	// ------------------------------------------------------------
	// register file
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < REG_COUNT; r++) begin
				regs[r] <= '0;
			end
		end else if (en_i && we_i) begin
			for (int i = 0; i < SEL_WIDTH; i++) begin
				if (sel_i[i]) begin
					regs[idx][8*i +: 8] <= wdata_i[8*i +: 8];
				end
			end
		end
	end

	// read data one cycle after acceptance
	always_ff @(posedge clk) begin
		if (en_i && !we_i) begin
			rdata_q <= regs[idx];
		end
	end

	assign rdata_o = rdata_q;
	assign gpio_o  = regs[0][GPIO_WIDTH-1:0];

endmodule

`default_nettype wire

// File: jbus_wait_sram.sv
`timescale 1ns/10ps
`default_nettype none

module jbus_wait_sram (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 en_i,
	input  wire                                 we_i,
	input  wire  [wbjb_pkg::SEL_WIDTH-1:0]      sel_i,
	input  wire  [wbjb_pkg::ADDR_WIDTH-1:0]     addr_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     wdata_i,
	output logic [wbjb_pkg::DATA_WIDTH-1:0]     rdata_o,
	output logic                                ready_o
);
	import wbjb_pkg::*;

	logic [DATA_WIDTH-1:0]     mem [RAM_DEPTH];
	logic [DATA_WIDTH-1:0]     rdata_q;
	logic [RAM_WAIT_WIDTH-1:0] wait_cnt;
	logic [RAM_ADDR_WIDTH-1:0] idx;
	logic                      accept;

	assign idx     = addr_i[RAM_ADDR_WIDTH-1:0];
	assign ready_o = (wait_cnt == '0);
	assign accept  = en_i & ready_o;

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (accept) begin
			if (we_i) begin
				for (int i = 0; i < SEL_WIDTH; i++) begin
					if (sel_i[i]) begin
						mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];
					end
				end
			end else begin
				// held until ready comes back
				rdata_q <= mem[idx];
			end
		end
	end

	assign rdata_o = rdata_q;

	// ------------------------------------------------------------
	// read wait states
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_cnt <= '0;
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - 1'b1;
		end else if (accept && !we_i) begin
			wait_cnt <= RAM_WAIT_WIDTH'(RAM_READ_WAIT);
		end
	end

	a_wait_range: assert property (@(posedge clk) disable iff (reset)
		wait_cnt <= RAM_WAIT_WIDTH'(RAM_READ_WAIT));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_wb_jbus -Mdir obj_dir \
	&& ./obj_dir/Vtb_wb_jbus > sim.log 2>&1 \
	|| echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// File: tb_wb_jbus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wb_jbus;
	import wbjb_pkg::*;

	localparam int ROWS           = 18;
	localparam int ROW_W          = $clog2(ROWS);
	localparam int TIMEOUT_CYCLES = 16 + ROWS * (4 + RAM_READ_WAIT) + 50;

	typedef struct packed {
		logic                  we;
		logic [ADDR_WIDTH-1:0] adr;
		logic [SEL_WIDTH-1:0]  sel;
		logic [DATA_WIDTH-1:0] dat;
		// expected read data, unused for writes
		logic [DATA_WIDTH-1:0] rd_exp;
		// idle cycle after the ack
		logic                  gap;
	} row_t;

	row_t                  rows [ROWS];
	logic [ROW_W-1:0]      cur_row;
	int                    cycles;
	int                    error_count;
	int                    ack_count;

	logic                  clk;
	logic                  reset;
	logic [ADDR_WIDTH-1:0] wb_adr;
	logic [DATA_WIDTH-1:0] wb_dat_w;
	logic                  wb_we;
	logic [SEL_WIDTH-1:0]  wb_sel;
	logic                  wb_stb;
	logic [DATA_WIDTH-1:0] wb_dat_r;
	logic                  wb_ack;
	logic [GPIO_WIDTH-1:0] gpio;
	logic [DATA_WIDTH-1:0] exp_dat;

	assign exp_dat = rows[cur_row].rd_exp;

	wb_jbus_top uut (
		.clk(clk),
		.reset(reset),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_we_i(wb_we),
		.wb_sel_i(wb_sel),
		.wb_stb_i(wb_stb),
		.wb_dat_o(wb_dat_r),
		.wb_ack_o(wb_ack),
		.gpio_o(gpio)
	);

	tb_wb_jbus_checker u_checker (
		.clk(clk),
		.reset(reset),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_we_i(wb_we),
		.wb_sel_i(wb_sel),
		.wb_stb_i(wb_stb),
		.dut_dat_i(wb_dat_r),
		.dut_ack_i(wb_ack),
		.dut_gpio_i(gpio),
		.exp_dat_i(exp_dat),
		.error_count_o(error_count),
		.ack_count_o(ack_count)
	);

	// ------------------------------------------------------------
	// transaction table: we, adr, sel, dat, read data, gap
	// ------------------------------------------------------------

	task automatic load_table();
		rows[0]  = '{1'b1, 12'h010, 4'hf, 32'h1122_3344, 32'h0000_0000, 1'b1};
		rows[1]  = '{1'b1, 12'h011, 4'hf, 32'ha5a5_5a5a, 32'h0000_0000, 1'b0};
		rows[2]  = '{1'b1, 12'h0ff, 4'hf, 32'hdead_beef, 32'h0000_0000, 1'b1};
		rows[3]  = '{1'b0, 12'h010, 4'hf, 32'h0000_0000, 32'h1122_3344, 1'b0};
		rows[4]  = '{1'b0, 12'h011, 4'hf, 32'h0000_0000, 32'ha5a5_5a5a, 1'b0};
		rows[5]  = '{1'b1, 12'h010, 4'h5, 32'hccdd_eeff, 32'h0000_0000, 1'b0};
		rows[6]  = '{1'b1, 12'h011, 4'h8, 32'h7700_0000, 32'h0000_0000, 1'b1};
		rows[7]  = '{1'b0, 12'h010, 4'hf, 32'h0000_0000, 32'h11dd_33ff, 1'b0};
		// register read right behind a memory read
		rows[8]  = '{1'b0, 12'h800, 4'hf, 32'h0000_0000, 32'h0000_0000, 1'b0};
		rows[9]  = '{1'b1, 12'h800, 4'h1, 32'h0000_00c3, 32'h0000_0000, 1'b1};
		rows[10] = '{1'b1, 12'h801, 4'hf, 32'h1234_5678, 32'h0000_0000, 1'b0};
		rows[11] = '{1'b0, 12'h801, 4'hf, 32'h0000_0000, 32'h1234_5678, 1'b0};
		rows[12] = '{1'b1, 12'h801, 4'h6, 32'habcd_ef01, 32'h0000_0000, 1'b0};
		// 805 aliases register 1
		rows[13] = '{1'b0, 12'h805, 4'hf, 32'h0000_0000, 32'h12cd_ef78, 1'b1};
		rows[14] = '{1'b1, 12'h800, 4'h3, 32'h0000_5a3c, 32'h0000_0000, 1'b0};
		// 3ff aliases memory word ff
		rows[15] = '{1'b0, 12'h3ff, 4'hf, 32'h0000_0000, 32'hdead_beef, 1'b0};
		rows[16] = '{1'b0, 12'h800, 4'hf, 32'h0000_0000, 32'h0000_5a3c, 1'b0};
		rows[17] = '{1'b0, 12'h011, 4'hf, 32'h0000_0000, 32'h77a5_5a5a, 1'b1};
	endtask

	task automatic present_row(input row_t row);
		wb_we    = row.we;
		wb_adr   = row.adr;
		wb_sel   = row.sel;
		wb_dat_w = row.dat;
		wb_stb   = 1'b1;
	endtask

	// returns just after the edge that takes the ack
	task automatic wait_for_ack();
		do begin
			@(negedge clk);
		end while (!wb_ack);
		@(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial begin
		reset    = 1'b1;
		wb_adr   = '0;
		wb_dat_w = '0;
		wb_we    = 1'b0;
		wb_sel   = '0;
		wb_stb   = 1'b0;
		cur_row  = '0;
		load_table();
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		@(posedge clk);
		#1;
		for (int r = 0; r < ROWS; r++) begin
			cur_row = ROW_W'(r);
			present_row(rows[cur_row]);
			wait_for_ack();
			if (rows[cur_row].gap) begin
				wb_stb = 1'b0;
				@(posedge clk);
				#1;
			end
		end
		wb_stb = 1'b0;
		repeat (4) @(posedge clk);
		$display("rows %0d, acks %0d, errors %0d", ROWS, ack_count, error_count);
		if (ack_count != ROWS) begin
			$display("ack count differs from the number of table rows");
		end
		if (error_count == 0 && ack_count == ROWS) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_wb_jbus_checker.sv
`timescale 1ns/10ps
`default_nettype none

module tb_wb_jbus_checker (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [wbjb_pkg::ADDR_WIDTH-1:0]     wb_adr_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     wb_dat_i,
	input  wire                                 wb_we_i,
	input  wire  [wbjb_pkg::SEL_WIDTH-1:0]      wb_sel_i,
	input  wire                                 wb_stb_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     dut_dat_i,
	input  wire                                 dut_ack_i,
	input  wire  [wbjb_pkg::GPIO_WIDTH-1:0]     dut_gpio_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     exp_dat_i,
	output int                                  error_count_o,
	output int                                  ack_count_o
);
	import wbjb_pkg::*;

	// longest wait for an ack before it counts as missing
	localparam int ACK_LIMIT = 4 + RAM_READ_WAIT + 4;

	logic [DATA_WIDTH-1:0] ref_mem [RAM_DEPTH];
	logic [DATA_WIDTH-1:0] ref_regs [REG_COUNT];
	int                    stall_cycles;
	logic                  stall_reported;

	// selected bytes come from the new word, the rest stay
	function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
			input logic [DATA_WIDTH-1:0] new_word, input logic [SEL_WIDTH-1:0] sel);
		logic [DATA_WIDTH-1:0] result;
		result = old_word;
		for (int i = 0; i < SEL_WIDTH; i++) begin
			if (sel[i]) begin
				result[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return result;
	endfunction

	// ------------------------------------------------------------
	// sampled mid-cycle, where every DUT output is settled
	// ------------------------------------------------------------

	always @(negedge clk) begin
		logic [DATA_WIDTH-1:0] expected;
		if (reset) begin
			for (int r = 0; r < REG_COUNT; r++) begin
				ref_regs[r] = '0;
			end
			stall_cycles   = 0;
			stall_reported = 1'b0;
			error_count_o  = 0;
			ack_count_o    = 0;
		end else begin
			if (dut_ack_i && !wb_stb_i) begin
				$display("error at %0t: ack seen with no strobe pending", $time);
				error_count_o++;
			end else if (dut_ack_i) begin
				ack_count_o++;
				stall_cycles   = 0;
				stall_reported = 1'b0;
				if (wb_we_i) begin
					// top address bit 0 is the memory
					if (!wb_adr_i[ADDR_WIDTH-1]) begin
						ref_mem[wb_adr_i[RAM_ADDR_WIDTH-1:0]] = merge_bytes(
							ref_mem[wb_adr_i[RAM_ADDR_WIDTH-1:0]], wb_dat_i, wb_sel_i);
					end else begin
						ref_regs[wb_adr_i[REG_ADDR_WIDTH-1:0]] = merge_bytes(
							ref_regs[wb_adr_i[REG_ADDR_WIDTH-1:0]], wb_dat_i, wb_sel_i);
					end
					$display("row %0d: write %h sel %b data %h done", ack_count_o - 1,
						wb_adr_i, wb_sel_i, wb_dat_i);
				end else begin
					if (!wb_adr_i[ADDR_WIDTH-1]) begin
						expected = ref_mem[wb_adr_i[RAM_ADDR_WIDTH-1:0]];
					end else begin
						expected = ref_regs[wb_adr_i[REG_ADDR_WIDTH-1:0]];
					end
					if (expected !== exp_dat_i) begin
						$display("row %0d: table value %h disagrees with the model value %h",
							ack_count_o - 1, exp_dat_i, expected);
						error_count_o++;
					end
					if (dut_dat_i !== expected) begin
						$display("error at %0t: wb_dat_o expected %h, got %h", $time,
							expected, dut_dat_i);
						error_count_o++;
					end else begin
						$display("row %0d: read %h returned %h", ack_count_o - 1,
							wb_adr_i, dut_dat_i);
					end
				end
			end else if (wb_stb_i) begin
				stall_cycles++;
				if (stall_cycles >= ACK_LIMIT && !stall_reported) begin
					$display("row %0d: no ack after %0d cycles of strobe", ack_count_o,
						ACK_LIMIT);
					stall_reported = 1'b1;
					error_count_o++;
				end
			end
			// after the ack update, so a register 0 write shows from the next cycle
			if (dut_gpio_i !== ref_regs[0][GPIO_WIDTH-1:0]) begin
				$display("error at %0t: gpio_o expected %h, got %h", $time,
					ref_regs[0][GPIO_WIDTH-1:0], dut_gpio_i);
				error_count_o++;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
wbjb_pkg.sv
wb_to_jbus_bridge.sv
jbus_addr_decoder.sv
jbus_wait_sram.sv
jbus_gpio_regs.sv
wb_jbus_top.sv
tb_wb_jbus_checker.sv
tb_wb_jbus.sv

// File: wb_jbus_top.sv
`timescale 1ns/10ps
`default_nettype none

module wb_jbus_top (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [wbjb_pkg::ADDR_WIDTH-1:0]     wb_adr_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     wb_dat_i,
	input  wire                                 wb_we_i,
	input  wire  [wbjb_pkg::SEL_WIDTH-1:0]      wb_sel_i,
	input  wire                                 wb_stb_i,
	output logic [wbjb_pkg::DATA_WIDTH-1:0]     wb_dat_o,
	output logic                                wb_ack_o,
	output logic [wbjb_pkg::GPIO_WIDTH-1:0]     gpio_o
);
	import wbjb_pkg::*;

	// ------------------------------------------------------------
	// bridge to decoder
	// ------------------------------------------------------------
	logic                  up_en;
	logic                  up_we;
	logic [SEL_WIDTH-1:0]  up_sel;
	logic [ADDR_WIDTH-1:0] up_addr;
	logic [DATA_WIDTH-1:0] up_wdata;
	logic [DATA_WIDTH-1:0] up_rdata;
	logic                  up_ready;

	// ------------------------------------------------------------
	// decoder to slaves
	// ------------------------------------------------------------
	logic                  dn_we;
	logic [SEL_WIDTH-1:0]  dn_sel;
	logic [ADDR_WIDTH-1:0] dn_addr;
	logic [DATA_WIDTH-1:0] dn_wdata;
	logic                  ram_en;
	logic [DATA_WIDTH-1:0] ram_rdata;
	logic                  ram_ready;
	logic                  reg_en;
	logic [DATA_WIDTH-1:0] reg_rdata;
	logic                  reg_ready;

	wb_to_jbus_bridge #(
		.pipelined(BRIDGE_PIPELINE)
	) u_bridge (
		.clk(clk),
		.reset(reset),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_we_i(wb_we_i),
		.wb_sel_i(wb_sel_i),
		.wb_stb_i(wb_stb_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.jb_en_o(up_en),
		.jb_we_o(up_we),
		.jb_sel_o(up_sel),
		.jb_addr_o(up_addr),
		.jb_wdata_o(up_wdata),
		.jb_rdata_i(up_rdata),
		.jb_ready_i(up_ready)
	);

	jbus_addr_decoder u_decoder (
		.clk(clk),
		.reset(reset),
		.up_en_i(up_en),
		.up_we_i(up_we),
		.up_sel_i(up_sel),
		.up_addr_i(up_addr),
		.up_wdata_i(up_wdata),
		.up_rdata_o(up_rdata),
		.up_ready_o(up_ready),
		.ram_en_o(ram_en),
		.ram_rdata_i(ram_rdata),
		.ram_ready_i(ram_ready),
		.reg_en_o(reg_en),
		.reg_rdata_i(reg_rdata),
		.reg_ready_i(reg_ready),
		.dn_we_o(dn_we),
		.dn_sel_o(dn_sel),
		.dn_addr_o(dn_addr),
		.dn_wdata_o(dn_wdata)
	);

	jbus_wait_sram u_sram (
		.clk(clk),
		.reset(reset),
		.en_i(ram_en),
		.we_i(dn_we),
		.sel_i(dn_sel),
		.addr_i(dn_addr),
		.wdata_i(dn_wdata),
		.rdata_o(ram_rdata),
		.ready_o(ram_ready)
	);

	jbus_gpio_regs u_regs (
		.clk(clk),
		.reset(reset),
		.en_i(reg_en),
		.we_i(dn_we),
		.sel_i(dn_sel),
		.addr_i(dn_addr),
		.wdata_i(dn_wdata),
		.rdata_o(reg_rdata),
		.ready_o(reg_ready),
		.gpio_o(gpio_o)
	);

endmodule

`default_nettype wire

// File: wb_to_jbus_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module wb_to_jbus_bridge #(
	parameter int pipelined = 1
) (
	input  wire                                 clk,
	input  wire                                 reset,

	// WISHBONE slave side
	input  wire  [wbjb_pkg::ADDR_WIDTH-1:0]     wb_adr_i,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     wb_dat_i,
	input  wire                                 wb_we_i,
	input  wire  [wbjb_pkg::SEL_WIDTH-1:0]      wb_sel_i,
	input  wire                                 wb_stb_i,
	output logic [wbjb_pkg::DATA_WIDTH-1:0]     wb_dat_o,
	output logic                                wb_ack_o,

	// jbus master side
	output logic                                jb_en_o,
	output logic                                jb_we_o,
	output logic [wbjb_pkg::SEL_WIDTH-1:0]      jb_sel_o,
	output logic [wbjb_pkg::ADDR_WIDTH-1:0]     jb_addr_o,
	output logic [wbjb_pkg::DATA_WIDTH-1:0]     jb_wdata_o,
	input  wire  [wbjb_pkg::DATA_WIDTH-1:0]     jb_rdata_i,
	input  wire                                 jb_ready_i
);
	import wbjb_pkg::*;

	// read accepted, data still to come
	logic rd_owed_q;
	// write accepted last cycle
	logic wr_ack_q;
	logic busy;

	assign busy = rd_owed_q | wr_ack_q;

	// ------------------------------------------------------------
	// ack tracking, common to both modes
	// ------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_owed_q <= 1'b0;
			wr_ack_q  <= 1'b0;
		end else begin
			// writes complete on acceptance
			wr_ack_q <= jb_en_o & jb_we_o & jb_ready_i;
			// first ready-high cycle after a read delivers its data
			if (jb_ready_i) begin
				rd_owed_q <= jb_en_o & ~jb_we_o;
			end
		end
	end

	assign wb_dat_o = jb_rdata_i;
	assign wb_ack_o = wr_ack_q | (rd_owed_q & jb_ready_i);

	// ------------------------------------------------------------
	// request path
	// ------------------------------------------------------------

	generate
		if (pipelined == 0) begin : g_pass
			// blocked during the ack cycle so a held stb is not reissued
			assign jb_en_o    = wb_stb_i & ~busy;
			assign jb_we_o    = wb_we_i;
			assign jb_sel_o   = wb_sel_i;
			assign jb_addr_o  = wb_adr_i;
			assign jb_wdata_o = wb_dat_i;
		end else begin : g_reg
			logic                  en_q;
			logic                  we_q;
			logic [SEL_WIDTH-1:0]  sel_q;
			logic [ADDR_WIDTH-1:0] addr_q;
			logic [DATA_WIDTH-1:0] wdata_q;

			always_ff @(posedge clk) begin
				if (reset) begin
					en_q <= 1'b0;
				end else if (jb_ready_i) begin
					// new cycle only when nothing is in flight
					en_q <= wb_stb_i & ~en_q & ~busy;
				end
			end

			always_ff @(posedge clk) begin
				if (jb_ready_i && !en_q) begin
					we_q    <= wb_we_i;
					sel_q   <= wb_sel_i;
					addr_q  <= wb_adr_i;
					wdata_q <= wb_dat_i;
				end
			end

			assign jb_en_o    = en_q;
			assign jb_we_o    = we_q;
			assign jb_sel_o   = sel_q;
			assign jb_addr_o  = addr_q;
			assign jb_wdata_o = wdata_q;
		end
	endgenerate

	// stalled request must not move
	a_stall_hold: assert property (@(posedge clk) disable iff (reset)
		jb_en_o && !jb_ready_i |=> jb_en_o && $stable(jb_we_o) && $stable(jb_sel_o)
			&& $stable(jb_addr_o) && $stable(jb_wdata_o));

endmodule

`default_nettype wire

// File: wbjb_pkg.sv
`default_nettype none

package wbjb_pkg;

	// ------------------------------------------------------------
	// bus geometry, shared by WISHBONE and jbus
	// ------------------------------------------------------------

	// word addresses on both buses
	localparam int ADDR_WIDTH = 12;

	// 0: 8 bit, 1: 16 bit, 2: 32 bit words
	localparam int DATA_SIZE  = 2;
	localparam int SEL_WIDTH  = (1 << DATA_SIZE);
	localparam int DATA_WIDTH = (8 << DATA_SIZE);

	// ------------------------------------------------------------
	// address map and slave sizes
	// ------------------------------------------------------------

	// top address bit, 0 picks the memory, 1 the registers
	localparam logic SEL_RAM = 1'b0;

	localparam int RAM_DEPTH      = 256;
	localparam int RAM_ADDR_WIDTH = $clog2(RAM_DEPTH);

	// ready held low this many cycles per memory read
	localparam int RAM_READ_WAIT  = 2;
	localparam int RAM_WAIT_WIDTH = $clog2(RAM_READ_WAIT + 1);

	localparam int REG_COUNT      = 4;
	localparam int REG_ADDR_WIDTH = $clog2(REG_COUNT);

	// low byte of register 0
	localparam int GPIO_WIDTH = 8;

	// 1 for registered bridge, 0 for pass-through
	localparam int BRIDGE_PIPELINE = 1;

endpackage

`default_nettype wire
